// File: memSys_params.svh
/*
  sizing for the data memory; bank count and bank depth must be powers of two
  data width stays at 32, the lane merge assumes four bytes per word
*/
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// number of word-interleaved banks, at least 2
`define MEM_NUM_BANKS 4

// words held by each bank
`define MEM_BANK_WORDS 256

// AXI4-Lite address width
`define MEM_ADDR_W 32

// data width, fixed
`define MEM_DATA_W 32

`endif

// File: memSysPkg.sv
/*
  types shared by the memory subsystem
  size codes follow the byte/half/word store scheme, response codes are AXI
*/
`include "memSys_params.svh"

package memSysPkg;

  // derived sizes
  localparam int MEM_WORDS = `MEM_NUM_BANKS * `MEM_BANK_WORDS;
  localparam int MEM_BYTES = MEM_WORDS * 4;
  localparam int WORD_ADDR_W = $clog2(MEM_WORDS);
  // bank select bits taken from the bottom of the word address
  localparam int BANK_IDX_W = $clog2(`MEM_NUM_BANKS);

  // transfer size, same codes as the low HSIZE bits
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } accessSizeT;

  // AXI response encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axiRespT;

  // one bank access
  // wdata is the AXI write data, lanes not shifted
  typedef struct packed {
    logic                   write;
    accessSizeT             size;
    logic [1:0]             offset;
    logic [WORD_ADDR_W-1:0] wordAddr;
    logic [`MEM_DATA_W-1:0] wdata;
  } memReqT;

endpackage

// File: axiLiteFront.sv
/*
  AXI4-Lite slave, one transaction at a time, write wins over read
  legal strobes are one byte, an aligned halfword or a full word; address bits [1:0] ignored
*/
`include "memSys_params.svh"

module axiLiteFront import memSysPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`MEM_ADDR_W-1:0]   awAddr,
  input  logic                     awValid,
  output logic                     awReady,
  input  logic [`MEM_DATA_W-1:0]   wData,
  input  logic [`MEM_DATA_W/8-1:0] wStrb,
  input  logic                     wValid,
  output logic                     wReady,
  output logic [1:0]               bResp,
  output logic                     bValid,
  input  logic                     bReady,
  input  logic [`MEM_ADDR_W-1:0]   arAddr,
  input  logic                     arValid,
  output logic                     arReady,
  output logic [`MEM_DATA_W-1:0]   rData,
  output logic [1:0]               rResp,
  output logic                     rValid,
  input  logic                     rReady,
  output memReqT                   req,
  output logic                     reqValid,
  input  logic [`MEM_DATA_W-1:0]   rdata,
  input  logic                     rdataValid
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RESP
  } stateT;

  localparam logic [`MEM_ADDR_W-1:0] MEM_LIMIT = MEM_BYTES;

  stateT                     state;
  logic                      awHave;
  logic                      wHave;
  logic [`MEM_ADDR_W-1:0]    awAddrHold;
  logic [`MEM_DATA_W-1:0]    wDataHold;
  logic [`MEM_DATA_W/8-1:0]  wStrbHold;
  logic [`MEM_DATA_W-1:0]    rDataHold;
  logic                      awDone;
  logic                      wDone;
  logic                      arDone;
  logic                      writeGo;
  logic [`MEM_ADDR_W-1:0]    wrAddr;
  logic [`MEM_DATA_W-1:0]    wrData;
  logic [`MEM_DATA_W/8-1:0]  wrStrb;
  accessSizeT                wrSize;
  logic [1:0]                wrOffset;
  logic                      strbOk;
  axiRespT                   wrResp;
  axiRespT                   rdResp;

  // readies only in idle, each write half taken once
  assign awReady = (state == ST_IDLE) && !awHave;
  assign wReady  = (state == ST_IDLE) && !wHave;
  // read held off while any write half is offered or captured
  assign arReady = (state == ST_IDLE) && !awHave && !wHave && !awValid && !wValid;

  assign awDone = awValid && awReady;
  assign wDone  = wValid && wReady;
  assign arDone = arValid && arReady;
  // second write half arriving completes the write
  assign writeGo = (awDone || awHave) && (wDone || wHave);

  // live channel value or the captured half
  assign wrAddr = awHave ? awAddrHold : awAddr;
  assign wrData = wHave ? wDataHold : wData;
  assign wrStrb = wHave ? wStrbHold : wStrb;

  // strobe to size and byte offset
  always_comb begin
    strbOk   = 1'b1;
    wrSize   = SIZE_WORD;
    wrOffset = 2'b00;
    unique case (wrStrb)
      4'b0001: wrSize = SIZE_BYTE;
      4'b0010: begin
        wrSize   = SIZE_BYTE;
        wrOffset = 2'b01;
      end
      4'b0100: begin
        wrSize   = SIZE_BYTE;
        wrOffset = 2'b10;
      end
      4'b1000: begin
        wrSize   = SIZE_BYTE;
        wrOffset = 2'b11;
      end
      4'b0011: wrSize = SIZE_HALF;
      4'b1100: begin
        wrSize   = SIZE_HALF;
        wrOffset = 2'b10;
      end
      4'b1111: wrSize = SIZE_WORD;
      // zero strobe and mixed lanes
      default: strbOk = 1'b0;
    endcase
  end

  // decode error ahead of slave error
  always_comb begin
    if (wrAddr >= MEM_LIMIT) begin
      wrResp = RESP_DECERR;
    end else if (!strbOk) begin
      wrResp = RESP_SLVERR;
    end else begin
      wrResp = RESP_OKAY;
    end
    rdResp = (arAddr >= MEM_LIMIT) ? RESP_DECERR : RESP_OKAY;
  end

  // bank word straight through on its valid cycle, held copy after
  assign rData = rdataValid ? rdata : rDataHold;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      awHave   <= 1'b0;
      wHave    <= 1'b0;
      reqValid <= 1'b0;
      bValid   <= 1'b0;
      rValid   <= 1'b0;
    end else begin
      // request strobe lasts one cycle
      reqValid <= 1'b0;
      unique case (state)
        ST_IDLE: begin
          if (writeGo) begin
            awHave <= 1'b0;
            wHave  <= 1'b0;
            if (wrResp == RESP_OKAY) begin
              reqValid <= 1'b1;
              state    <= ST_REQ;
            end else begin
              // no bank access, answer next cycle
              bValid <= 1'b1;
              state  <= ST_RESP;
            end
          end else if (arDone) begin
            if (rdResp == RESP_OKAY) begin
              reqValid <= 1'b1;
              state    <= ST_REQ;
            end else begin
              rValid <= 1'b1;
              state  <= ST_RESP;
            end
          end else begin
            if (awDone) begin
              awHave <= 1'b1;
            end
            if (wDone) begin
              wHave <= 1'b1;
            end
          end
        end
        ST_REQ: begin
          // bank done this cycle, response valid from the next
          if (req.write) begin
            bValid <= 1'b1;
          end else begin
            rValid <= 1'b1;
          end
          state <= ST_RESP;
        end
        default: begin
          if ((bValid && bReady) || (rValid && rReady)) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (awDone) begin
      awAddrHold <= awAddr;
    end
    if (wDone) begin
      wDataHold <= wData;
      wStrbHold <= wStrb;
    end
    if (writeGo) begin
      req.write    <= 1'b1;
      req.size     <= wrSize;
      req.offset   <= wrOffset;
      req.wordAddr <= wrAddr[WORD_ADDR_W+1:2];
      req.wdata    <= wrData;
      bResp        <= wrResp;
    end else if (arDone) begin
      req.write    <= 1'b0;
      req.size     <= SIZE_WORD;
      req.offset   <= 2'b00;
      req.wordAddr <= arAddr[WORD_ADDR_W+1:2];
      req.wdata    <= '0;
      rResp        <= rdResp;
      // failed read returns zero data
      rDataHold    <= '0;
    end else if (rdataValid) begin
      rDataHold <= rdata;
    end
  end

endmodule

// File: bankRouter.sv
/*
  word-interleaved bank routing, low word address bits pick the bank
  readBank is valid the cycle after a read request
*/
`include "memSys_params.svh"

module bankRouter import memSysPkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  memReqT                    req,
  input  logic                      reqValid,
  output logic [`MEM_NUM_BANKS-1:0] bankSel,
  output memReqT                    bankReq,
  output logic [BANK_IDX_W-1:0]     readBank
);

  logic [BANK_IDX_W-1:0] bankIdx;

  // bank number from the bottom of the word address
  assign bankIdx = req.wordAddr[BANK_IDX_W-1:0];

  // one-hot select, only while the request strobe is up
  always_comb begin
    bankSel          = '0;
    bankSel[bankIdx] = reqValid;
  end

  // same request, word address reduced to the index inside the bank
  always_comb begin
    bankReq          = req;
    bankReq.wordAddr = req.wordAddr >> BANK_IDX_W;
  end

  // remember which bank answers the read
  // merger uses it when the bank word comes out next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      readBank <= '0;
    end else if (reqValid && !req.write) begin
      readBank <= bankIdx;
    end
  end

endmodule

// File: dataMemBank.sv
/*
  one bank, no reset and no preload, contents undefined until written
  DEPTH must not exceed the word index range of the request
*/
`include "memSys_params.svh"

module dataMemBank import memSysPkg::*; #(
  parameter int DEPTH = `MEM_BANK_WORDS
) (
  input  logic                   clk,
  input  logic                   sel,
  input  memReqT                 bankReq,
  output logic [`MEM_DATA_W-1:0] rdata
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [`MEM_DATA_W-1:0]   mem [DEPTH];
  logic [IDX_W-1:0]         wordIdx;
  logic [`MEM_DATA_W-1:0]   oldWord;
  logic [`MEM_DATA_W-1:0]   newWord;
  logic [`MEM_DATA_W/8-1:0] laneEn;

  assign wordIdx = bankReq.wordAddr[IDX_W-1:0];
  assign oldWord = mem[wordIdx];

  // lanes touched by the store
  always_comb begin
    laneEn = '0;
    unique case (bankReq.size)
      SIZE_BYTE: laneEn[bankReq.offset] = 1'b1;
      // upper or lower half by offset bit 1
      SIZE_HALF: laneEn = bankReq.offset[1] ? 4'b1100 : 4'b0011;
      default:   laneEn = 4'b1111;
    endcase
  end

  // written lanes from the same lanes of wdata, rest from the stored word
  always_comb begin
    for (int i = 0; i < `MEM_DATA_W / 8; i++) begin
      newWord[8*i +: 8] = laneEn[i] ? bankReq.wdata[8*i +: 8] : oldWord[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (sel && bankReq.write) begin
      mem[wordIdx] <= newWord;
    end
  end

  // registered read port, holds the last read word
  always_ff @(posedge clk) begin
    if (sel && !bankReq.write) begin
      rdata <= oldWord;
    end
  end

endmodule

// File: respMerge.sv
/*
  selects the answering bank's read word
  rdataValid follows a read request by one cycle
*/
`include "memSys_params.svh"

module respMerge import memSysPkg::*; (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [`MEM_NUM_BANKS-1:0][`MEM_DATA_W-1:0] bankData,
  input  logic [BANK_IDX_W-1:0]                     readBank,
  input  logic                                      reqValid,
  input  logic                                      reqWrite,
  output logic [`MEM_DATA_W-1:0]                    rdata,
  output logic                                      rdataValid
);

  logic readPending;

  // read issued this cycle, bank word out next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      readPending <= 1'b0;
    end else begin
      readPending <= reqValid && !reqWrite;
    end
  end

  assign rdataValid = readPending;
  assign rdata      = bankData[readBank];

endmodule

// File: memSys.sv
/*
  data memory top, AXI4-Lite slave over word-interleaved banks
  AXI protection bits are not taken, bursts are not supported
*/
`include "memSys_params.svh"

module memSys import memSysPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`MEM_ADDR_W-1:0]   awAddr,
  input  logic                     awValid,
  output logic                     awReady,
  input  logic [`MEM_DATA_W-1:0]   wData,
  input  logic [`MEM_DATA_W/8-1:0] wStrb,
  input  logic                     wValid,
  output logic                     wReady,
  output logic [1:0]               bResp,
  output logic                     bValid,
  input  logic                     bReady,
  input  logic [`MEM_ADDR_W-1:0]   arAddr,
  input  logic                     arValid,
  output logic                     arReady,
  output logic [`MEM_DATA_W-1:0]   rData,
  output logic [1:0]               rResp,
  output logic                     rValid,
  input  logic                     rReady
);

  memReqT                                     req;
  logic                                       reqValid;
  memReqT                                     bankReq;
  logic [`MEM_NUM_BANKS-1:0]                  bankSel;
  logic [BANK_IDX_W-1:0]                      readBank;
  logic [`MEM_NUM_BANKS-1:0][`MEM_DATA_W-1:0] bankData;
  logic [`MEM_DATA_W-1:0]                     rdata;
  logic                                       rdataValid;

  axiLiteFront front (
    .clk(clk), .rst(rst),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .req(req), .reqValid(reqValid),
    .rdata(rdata), .rdataValid(rdataValid)
  );

  bankRouter router (
    .clk(clk), .rst(rst),
    .req(req), .reqValid(reqValid),
    .bankSel(bankSel), .bankReq(bankReq), .readBank(readBank)
  );

  // all banks see the same request, only the selected one acts
  for (genvar g = 0; g < `MEM_NUM_BANKS; g++) begin : gBank
    dataMemBank #(.DEPTH(`MEM_BANK_WORDS)) bank (
      .clk(clk), .sel(bankSel[g]), .bankReq(bankReq), .rdata(bankData[g])
    );
  end

  respMerge merge (
    .clk(clk), .rst(rst),
    .bankData(bankData), .readBank(readBank),
    .reqValid(reqValid), .reqWrite(req.write),
    .rdata(rdata), .rdataValid(rdataValid)
  );

endmodule

// File: memSys_chk.sv
/*
  AXI4-Lite channel checks bound into memSys
  assumes one transaction in flight, as the slave enforces
*/
`include "memSys_params.svh"

module memSys_chk import memSysPkg::*; (
  input logic                     clk,
  input logic                     rst,
  input logic [`MEM_ADDR_W-1:0]   awAddr,
  input logic                     awValid,
  input logic                     awReady,
  input logic [`MEM_DATA_W-1:0]   wData,
  input logic [`MEM_DATA_W/8-1:0] wStrb,
  input logic                     wValid,
  input logic                     wReady,
  input logic [1:0]               bResp,
  input logic                     bValid,
  input logic                     bReady,
  input logic [`MEM_ADDR_W-1:0]   arAddr,
  input logic                     arValid,
  input logic                     arReady,
  input logic [`MEM_DATA_W-1:0]   rData,
  input logic [1:0]               rResp,
  input logic                     rValid,
  input logic                     rReady
);
  timeunit 1ns;
  timeprecision 1ps;

  logic awSeen;
  logic wSeen;
  logic awXfer;
  logic wXfer;
  logic arXfer;
  logic writeAcc;
  logic busy;

  assign awXfer = awValid && awReady;
  assign wXfer  = wValid && wReady;
  assign arXfer = arValid && arReady;
  // write accepted on the edge where the later half transfers
  assign writeAcc = (awXfer || wXfer) && (awXfer || awSeen) && (wXfer || wSeen);

  always_ff @(posedge clk) begin
    if (rst || writeAcc) begin
      awSeen <= 1'b0;
      wSeen  <= 1'b0;
    end else begin
      if (awXfer) begin
        awSeen <= 1'b1;
      end
      if (wXfer) begin
        wSeen <= 1'b1;
      end
    end
  end

  // open from acceptance until the response transfers
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (writeAcc || arXfer) begin
      busy <= 1'b1;
    end else if ((bValid && bReady) || (rValid && rReady)) begin
      busy <= 1'b0;
    end
  end

  // valids hold with their payload until ready
  awHold: assert property (@(posedge clk) disable iff (rst)
    awValid && !awReady |=> awValid && $stable(awAddr)) else $error("AW dropped early");
  wHold: assert property (@(posedge clk) disable iff (rst)
    wValid && !wReady |=> wValid && $stable(wData) && $stable(wStrb)) else $error("W dropped early");
  arHold: assert property (@(posedge clk) disable iff (rst)
    arValid && !arReady |=> arValid && $stable(arAddr)) else $error("AR dropped early");
  bHold: assert property (@(posedge clk) disable iff (rst)
    bValid && !bReady |=> bValid && $stable(bResp)) else $error("B dropped early");
  rHold: assert property (@(posedge clk) disable iff (rst)
    rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp)) else $error("R dropped early");

  // nothing new accepted while a transaction is open or answered
  respBlocks: assert property (@(posedge clk) disable iff (rst)
    busy || bValid || rValid |-> !awReady && !wReady && !arReady) else $error("ready while busy");

  // OKAY two cycles after acceptance, errors after one
  okLatency: assert property (@(posedge clk) disable iff (rst)
    $rose(bValid) && bResp == RESP_OKAY |-> $past(writeAcc, 2)) else $error("late OKAY write");
  errLatency: assert property (@(posedge clk) disable iff (rst)
    $rose(bValid) && bResp != RESP_OKAY |-> $past(writeAcc)) else $error("late error write");
  bArrives: assert property (@(posedge clk) disable iff (rst)
    $past(writeAcc, 2) && !$past(bValid) |-> bValid) else $error("write without BVALID");

endmodule

bind memSys memSys_chk chk (
  .clk(clk), .rst(rst),
  .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
  .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
  .bResp(bResp), .bValid(bValid), .bReady(bReady),
  .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
  .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady)
);

// File: memSys_tb.sv
/*
  testbench for memSys, transactions and expected results from memSys_stim.txt
  run from the project root, response readies delayed 0 to 3 cycles at random
*/
`include "memSys_params.svh"

module memSys_tb import memSysPkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;
  // per transaction, well above handshake plus latency plus ready delay
  localparam int TX_CYCLES = 16;
  localparam logic [`MEM_ADDR_W-1:0] MEM_SIZE = `MEM_NUM_BANKS * `MEM_BANK_WORDS * 4;

  typedef struct packed {
    logic [7:0]             testNum;
    logic                   isWrite;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
    logic [3:0]             strb;
    logic [`MEM_DATA_W-1:0] expData;
    logic [1:0]             expResp;
  } stimRecT;

  logic                     clk;
  logic                     rst;
  logic [`MEM_ADDR_W-1:0]   awAddr;
  logic                     awValid;
  logic                     awReady;
  logic [`MEM_DATA_W-1:0]   wData;
  logic [`MEM_DATA_W/8-1:0] wStrb;
  logic                     wValid;
  logic                     wReady;
  logic [1:0]               bResp;
  logic                     bValid;
  logic                     bReady;
  logic [`MEM_ADDR_W-1:0]   arAddr;
  logic                     arValid;
  logic                     arReady;
  logic [`MEM_DATA_W-1:0]   rData;
  logic [1:0]               rResp;
  logic                     rValid;
  logic                     rReady;

  stimRecT     txQ[$];
  logic [31:0] rngState = 32'h9ae7_7284;
  int          errors = 0;
  logic        loaded = 1'b0;

  memSys DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic loadStim();
    int                     fd;
    int                     tNum;
    int                     op;
    string                  line;
    logic [`MEM_ADDR_W-1:0] a;
    logic [`MEM_DATA_W-1:0] d;
    logic [`MEM_DATA_W-1:0] ed;
    logic [3:0]             s;
    logic [1:0]             er;
    stimRecT                rec;
    fd = $fopen("memSys_stim.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      // comment and blank lines fail the scan
      if ($fgets(line, fd) > 0 && $sscanf(line, "%d %d %h %h %h %h %h",
          tNum, op, a, d, s, ed, er) == 7) begin
        rec.testNum = 8'(tNum);
        rec.isWrite = (op != 0);
        rec.addr    = a;
        rec.data    = d;
        rec.strb    = s;
        rec.expData = ed;
        rec.expResp = er;
        // anything past the end can only decode-fail
        assert (a < MEM_SIZE || er == RESP_DECERR) else begin
          $display("stim file: test %0d address %h is beyond the memory but expects no DECERR",
                   tNum, a);
          errors++;
        end
        txQ.push_back(rec);
      end
    end
    $fclose(fd);
  endtask

  task automatic writeTx(input stimRecT tx);
    logic awPend;
    logic wPend;
    logic awGo;
    logic wGo;
    rngState = xorshift(rngState);
    awAddr  <= tx.addr;
    wData   <= tx.data;
    wStrb   <= tx.strb;
    // bit 1 holds AW back a cycle, otherwise bit 0 holds W back
    awValid <= !rngState[1];
    wValid  <= rngState[1] || !rngState[0];
    awPend = 1'b1;
    wPend  = 1'b1;
    while (awPend || wPend) begin
      @(negedge clk);
      awGo = awPend && awValid && awReady;
      wGo  = wPend && wValid && wReady;
      @(posedge clk);
      if (awGo) begin
        awPend = 1'b0;
        awValid <= 1'b0;
      end else if (awPend) begin
        awValid <= 1'b1;
      end
      if (wGo) begin
        wPend = 1'b0;
        wValid <= 1'b0;
      end else if (wPend) begin
        wValid <= 1'b1;
      end
    end
  endtask

  task automatic readTx(input stimRecT tx);
    logic arGo;
    arAddr  <= tx.addr;
    arValid <= 1'b1;
    arGo = 1'b0;
    while (!arGo) begin
      @(negedge clk);
      arGo = arReady;
      @(posedge clk);
    end
    arValid <= 1'b0;
  endtask

  task automatic takeResponse(input logic isWrite, output logic [`MEM_DATA_W-1:0] data,
                              output logic [1:0] resp);
    logic done;
    rngState = xorshift(rngState);
    // master idles 0 to 3 cycles before taking the answer
    repeat (rngState[1:0]) @(posedge clk);
    if (isWrite) begin
      bReady <= 1'b1;
    end else begin
      rReady <= 1'b1;
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = isWrite ? bValid : rValid;
      data = rData;
      resp = isWrite ? bResp : rResp;
      @(posedge clk);
    end
    bReady <= 1'b0;
    rReady <= 1'b0;
  endtask

  function automatic void reportTest(int num, int txs, int errs);
    $display("test %0d finished: %0d transactions, %0d errors, %s", num, txs, errs,
             errs == 0 ? "ok" : "FAILED");
  endfunction

  // watchdog, budget scales with the stim file
  initial begin
    wait (loaded);
    repeat (RESET_CYCLES + txQ.size() * TX_CYCLES) @(posedge clk);
    $display("timeout: the DUT did not finish the stim file within its cycle budget");
    $display("Test failures found");
    $finish;
  end

  initial begin
    stimRecT                tx;
    logic [`MEM_DATA_W-1:0] gotData;
    logic [1:0]             gotResp;
    int                     curTest;
    int                     testTx;
    int                     testErr;
    int                     tests;
    rst     <= 1'b1;
    awAddr  <= '0;
    awValid <= 1'b0;
    wData   <= '0;
    wStrb   <= '0;
    wValid  <= 1'b0;
    bReady  <= 1'b0;
    arAddr  <= '0;
    arValid <= 1'b0;
    rReady  <= 1'b0;
    loadStim();
    loaded = 1'b1;
    if (txQ.size() == 0) begin
      $display("memSys_stim.txt is missing or holds no transactions");
      $display("Test failures found");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      curTest = int'(txQ[0].testNum);
      testTx  = 0;
      testErr = 0;
      tests   = 0;
      foreach (txQ[i]) begin
        tx = txQ[i];
        // test number changed, close the previous one
        if (int'(tx.testNum) != curTest) begin
          reportTest(curTest, testTx, testErr);
          tests++;
          curTest = int'(tx.testNum);
          testTx  = 0;
          testErr = 0;
        end
        if (tx.isWrite) begin
          writeTx(tx);
        end else begin
          readTx(tx);
        end
        takeResponse(tx.isWrite, gotData, gotResp);
        testTx++;
        // write data is not returned, only its response counts
        assert (gotResp == tx.expResp && (tx.isWrite || gotData == tx.expData)) else begin
          $display("mismatch at %0d ns: test %0d %s %h got data %h resp %0d, expected %h resp %0d",
                   $time, tx.testNum, tx.isWrite ? "write" : "read", tx.addr,
                   gotData, gotResp, tx.expData, tx.expResp);
          errors++;
          testErr++;
        end
      end
      reportTest(curTest, testTx, testErr);
      tests++;
      $display("%0d tests, %0d transactions, %0d errors", tests, txQ.size(), errors);
      if (errors == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

// File: memSys_stim.txt
# test op(1 write, 0 read) addr data strb expData expResp; test and op decimal, rest hex
# expResp 0 OKAY, 2 SLVERR, 3 DECERR; expData compared on reads only
1 1 00000000 11223344 f 00000000 0
1 1 00000004 a5a5f00d f 00000000 0
1 1 0000000c 0badbeef f 00000000 0
1 1 00000408 cafe0002 f 00000000 0
1 0 00000000 00000000 0 11223344 0
1 0 00000004 00000000 0 a5a5f00d 0
1 0 0000000c 00000000 0 0badbeef 0
1 0 00000408 00000000 0 cafe0002 0
2 1 00000008 77777711 1 00000000 0
2 1 00000009 77772277 2 00000000 0
2 1 0000000a 77337777 4 00000000 0
2 1 0000000b 44777777 8 00000000 0
2 0 00000008 00000000 0 44332211 0
2 0 00000004 00000000 0 a5a5f00d 0
2 0 0000000c 00000000 0 0badbeef 0
3 1 00000200 89abcdef f 00000000 0
3 1 00000200 99991234 3 00000000 0
3 0 00000200 00000000 0 89ab1234 0
3 1 00000202 5678aaaa c 00000000 0
3 0 00000200 00000000 0 56781234 0
4 1 00000300 01020304 f 00000000 0
4 1 00000300 ffffffff 5 00000000 2
4 1 00000301 ffffffff 6 00000000 2
4 1 00000300 ffffffff 0 00000000 2
4 0 00000300 00000000 0 01020304 0
5 1 00001000 12345678 f 00000000 3
5 1 00002000 12345678 5 00000000 3
5 0 00001000 00000000 0 00000000 3
5 0 fffffffc 00000000 0 00000000 3
6 1 00000010 13579bdf f 00000000 0
6 1 00000013 ab000000 8 00000000 0
6 1 00000010 ffffffff 9 00000000 2
6 0 00000010 00000000 0 ab579bdf 0
6 0 00001004 00000000 0 00000000 3

// File: memSys.f
+incdir+.
memSysPkg.sv
axiLiteFront.sv
bankRouter.sv
dataMemBank.sv
respMerge.sv
memSys.sv
memSys_chk.sv
memSys_tb.sv

// File: Makefile
# Verilator build and run of the memSys testbench
BIN  := obj_dir/VmemSys_tb
SRCS := $(filter-out +incdir+%,$(shell cat memSys.f))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

$(BIN): memSys.f memSys_params.svh $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module memSys_tb -f memSys.f

clean:
	rm -rf obj_dir
